/* bus_phase_ctrl.sv */
// Processor cycle phase control
`timescale 1ns/1ps

module bus_phase_ctrl #(
    parameter int PHASES = 4  // Fast clocks per processor cycle
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_run,
    input  calc_pkg::cpu_bus_t i_bus,
    output logic               o_step,
    output logic               o_wr_strobe
);

    localparam int PW = (PHASES > 1) ? $clog2(PHASES) : 1;
    localparam logic [PW-1:0] LAST = PW'(PHASES - 1);

    logic [PW-1:0] phase;  // Position inside processor cycle

    // Phase counter, parked at zero while stopped
    always_ff @(posedge clk) begin
        if (i_reset || !i_run) begin
            phase <= '0;
        end else if (phase == LAST) begin
            phase <= '0;  // Next processor cycle
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Core samples read data and advances on the last phase
    assign o_step = (phase == LAST);

    // Bus settled one clock earlier, single write in first phase
    assign o_wr_strobe = (phase == '0) && i_bus.we;

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_step_strobe_apart : assert property (@(posedge clk) disable iff (i_reset)
        !(o_step && o_wr_strobe));

    // At most one store per processor cycle
    a_one_strobe : assert property (@(posedge clk) disable iff (i_reset || !i_run)
        o_wr_strobe |=> (!o_wr_strobe throughout o_step[->1]));

endmodule

/* calc_pkg.sv */
// Calculator shared types
package calc_pkg;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam logic [15:0] LED_ADDR = 16'hC000;  // LED port, not backed by RAM
    localparam logic [15:0] RESET_PC = 16'h0000;  // First fetch after run

    // ------------------------------------------------------------------------
    // Buses
    // ------------------------------------------------------------------------

    // Processor request, one per processor cycle
    typedef struct packed {
        logic [15:0] addr;   // Byte address
        logic [7:0]  wdata;  // Store data
        logic        we;     // Store in this cycle
    } cpu_bus_t;

    // Host write into program RAM
    typedef struct packed {
        logic        en;     // One byte per clock
        logic [15:0] addr;
        logic [7:0]  data;
    } load_bus_t;

    // ------------------------------------------------------------------------
    // Processor
    // ------------------------------------------------------------------------

    // Supported 6502 opcodes, standard encodings
    typedef enum logic [7:0] {
        OP_BRK     = 8'h00,  // Halt
        OP_CLC     = 8'h18,
        OP_JMP_ABS = 8'h4C,
        OP_ADC_IMM = 8'h69,
        OP_TXA     = 8'h8A,
        OP_STA_ABS = 8'h8D,
        OP_LDX_IMM = 8'hA2,
        OP_LDA_IMM = 8'hA9,
        OP_LDA_ABS = 8'hAD,
        OP_DEX     = 8'hCA,
        OP_BNE     = 8'hD0,
        OP_INX     = 8'hE8
    } opcode_e;

    // Status bits kept by the core
    typedef struct packed {
        logic z;  // Last result was zero
        logic c;  // Carry out of ADC
    } flags_t;

endpackage

/* calc_vectors.txt */
// Each test has a header of program length, LED change count and loop factor
// followed by the program bytes from address 0000 and the expected LED values
05
// Several LED stores in order
15 04 02
A9 05 8D 00 C0 A9 0A 8D 00 C0 A9 03 8D 00 C0 A9 FC 8D 00 C0 00
05 0A 03 0C
// CLC and ADC wrapping past FF, then carry in
13 03 02
18 A9 F0 69 25 8D 00 C0 69 01 8D 00 C0 69 08 8D 00 C0 00
05 07 0F
// RAM store then absolute load back to the LEDs
1C 03 02
A9 3B 8D 00 02 A9 C6 8D 01 02 A9 04 8D 00 C0 AD 00 02 8D 00 C0 AD 01 02 8D 00 C0 00
04 0B 06
// DEX TXA STA BNE countdown from five
0A 05 03
A2 05 CA 8A 8D 00 C0 D0 F9 00
04 03 02 01 00
// INX, JMP over dead code and X wrapping to zero
1A 03 02
A2 0D E8 8A 8D 00 C0 4C 0D 00 A9 01 00 E8 8A 8D 00 C0 A2 FF E8 8A 8D 00 C0 00
0E 0F 00

/* cpu_core.sv */
// 6502 subset processor core
`timescale 1ns/1ps

module cpu_core (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_run,
    input  logic               i_step,   // One per processor cycle
    input  logic [7:0]         i_rdata,  // Valid on step
    output calc_pkg::cpu_bus_t o_bus,
    output logic               o_halt
);

    typedef enum logic [1:0] {
        S_FETCH,  // Opcode read at pc
        S_OPLO,   // First operand byte
        S_OPHI,   // High address byte
        S_EXEC    // Execute, absolute read or store
    } state_e;

    state_e            state;
    calc_pkg::opcode_e ir;       // Current opcode
    logic [7:0]        opnd_lo;  // Immediate, offset or address low
    logic [7:0]        opnd_hi;  // Address high
    logic [15:0]       pc;
    logic [7:0]        a;
    logic [7:0]        x;
    calc_pkg::flags_t  flags;
    logic              run_rst;  // Stop acts as reset
    logic [8:0]        adc_sum;  // Carry in bit 8
    logic [7:0]        x_inc;
    logic [7:0]        x_dec;
    logic [15:0]       br_target;

    // ------------------------------------------------------------------------
    // Decode helpers
    // ------------------------------------------------------------------------

    // Opcode is followed by at least one byte
    function automatic logic has_operand(input calc_pkg::opcode_e op);
        case (op)
            calc_pkg::OP_LDA_IMM, calc_pkg::OP_LDA_ABS, calc_pkg::OP_STA_ABS,
            calc_pkg::OP_ADC_IMM, calc_pkg::OP_LDX_IMM, calc_pkg::OP_JMP_ABS,
            calc_pkg::OP_BNE:
                return 1'b1;
            default:
                return 1'b0;  // Implied, BRK, unknown
        endcase
    endfunction

    // Two operand bytes
    function automatic logic is_absolute(input calc_pkg::opcode_e op);
        case (op)
            calc_pkg::OP_LDA_ABS, calc_pkg::OP_STA_ABS, calc_pkg::OP_JMP_ABS:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    assign run_rst = i_reset | ~i_run;

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    assign adc_sum   = {1'b0, a} + {1'b0, opnd_lo} + {8'd0, flags.c};
    assign x_inc     = x + 8'd1;
    assign x_dec     = x - 8'd1;
    assign br_target = pc + {{8{opnd_lo[7]}}, opnd_lo};  // pc already past offset

    // Opcode and operand latches
    always_ff @(posedge clk) begin
        if (i_step) begin
            case (state)
                S_FETCH: ir      <= calc_pkg::opcode_e'(i_rdata);
                S_OPLO:  opnd_lo <= i_rdata;
                S_OPHI:  opnd_hi <= i_rdata;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM and registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (run_rst) begin
            state  <= S_FETCH;
            pc     <= calc_pkg::RESET_PC;
            a      <= '0;
            x      <= '0;
            flags  <= '0;
            o_halt <= 1'b0;
        end else if (i_step && !o_halt) begin
            case (state)
                S_FETCH: begin
                    pc    <= pc + 16'd1;
                    state <= has_operand(calc_pkg::opcode_e'(i_rdata)) ? S_OPLO : S_EXEC;
                end
                S_OPLO: begin
                    pc    <= pc + 16'd1;
                    state <= is_absolute(ir) ? S_OPHI : S_EXEC;
                end
                S_OPHI: begin
                    pc    <= pc + 16'd1;
                    state <= S_EXEC;
                end
                default: begin  // S_EXEC
                    state <= S_FETCH;
                    case (ir)
                        calc_pkg::OP_LDA_IMM: begin
                            a       <= opnd_lo;
                            flags.z <= (opnd_lo == 8'd0);
                        end
                        calc_pkg::OP_LDA_ABS: begin
                            a       <= i_rdata;  // Read at operand address
                            flags.z <= (i_rdata == 8'd0);
                        end
                        calc_pkg::OP_STA_ABS: ;  // Write done by strobe
                        calc_pkg::OP_ADC_IMM: begin
                            a       <= adc_sum[7:0];
                            flags.c <= adc_sum[8];
                            flags.z <= (adc_sum[7:0] == 8'd0);
                        end
                        calc_pkg::OP_CLC: flags.c <= 1'b0;
                        calc_pkg::OP_LDX_IMM: begin
                            x       <= opnd_lo;
                            flags.z <= (opnd_lo == 8'd0);
                        end
                        calc_pkg::OP_INX: begin
                            x       <= x_inc;
                            flags.z <= (x_inc == 8'd0);
                        end
                        calc_pkg::OP_DEX: begin
                            x       <= x_dec;
                            flags.z <= (x_dec == 8'd0);
                        end
                        calc_pkg::OP_TXA: begin
                            a       <= x;
                            flags.z <= (x == 8'd0);
                        end
                        calc_pkg::OP_JMP_ABS: pc <= {opnd_hi, opnd_lo};
                        calc_pkg::OP_BNE: begin
                            if (!flags.z) begin
                                pc <= br_target;
                            end
                        end
                        default: begin  // BRK and unknown opcodes
                            o_halt <= 1'b1;
                            state  <= S_EXEC;
                        end
                    endcase
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Memory bus
    // ------------------------------------------------------------------------
    always_comb begin
        o_bus.addr  = pc;  // Fetch and operand reads
        o_bus.wdata = a;
        o_bus.we    = 1'b0;
        if (state == S_EXEC &&
            (ir == calc_pkg::OP_LDA_ABS || ir == calc_pkg::OP_STA_ABS)) begin
            o_bus.addr = {opnd_hi, opnd_lo};
            o_bus.we   = (ir == calc_pkg::OP_STA_ABS);
        end
    end

    // Store state entered only once both address bytes are in
    a_we_in_store : assert property (@(posedge clk) disable iff (run_rst)
        $rose(o_bus.we) |-> ($past(state) == S_OPHI));

endmodule

/* led_port.sv */
// Memory mapped LED register
`timescale 1ns/1ps

module led_port (
    input  logic               clk,
    input  logic               i_reset,
    input  calc_pkg::cpu_bus_t i_bus,
    input  logic               i_wr_strobe,
    output logic [3:0]         o_led
);

    logic hit;  // Store aimed at the LED address

    assign hit = i_wr_strobe && (i_bus.addr == calc_pkg::LED_ADDR);

    // Low nibble of the stored byte
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_led <= '0;
        end else if (hit) begin
            o_led <= i_bus.wdata[3:0];
        end
    end

endmodule

/* list.f */
calc_pkg.sv
bus_phase_ctrl.sv
cpu_core.sv
program_ram.sv
led_port.sv
marsohod_calc_top.sv
tb_calc.sv

/* marsohod_calc_top.sv */
// Calculator subsystem top level
`timescale 1ns/1ps

module marsohod_calc_top #(
    parameter int PHASES     = 4,   // Fast clocks per processor cycle
    parameter int RAM_ADDR_W = 10
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_run,   // Low stops and resets the core
    input  calc_pkg::load_bus_t i_load,
    output logic [3:0]          o_led,
    output logic                o_halt
);

    calc_pkg::cpu_bus_t  cpu_bus;
    calc_pkg::load_bus_t load_bus;   // Host port, blocked while running
    logic [7:0]          rdata;
    logic                step;
    logic                wr_strobe;
    logic                led_reset;  // LEDs clear on stop as well

    assign load_bus.en   = i_load.en & ~i_run;
    assign load_bus.addr = i_load.addr;
    assign load_bus.data = i_load.data;
    assign led_reset     = i_reset | ~i_run;

    // ------------------------------------------------------------------------
    // Phase control, processor, memory and LED port
    // ------------------------------------------------------------------------
    bus_phase_ctrl #(
        .PHASES (PHASES)
    ) u_bus_phase_ctrl (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_bus       (cpu_bus),
        .o_step      (step),
        .o_wr_strobe (wr_strobe)
    );

    cpu_core u_cpu_core (
        .clk     (clk),
        .i_reset (i_reset),
        .i_run   (i_run),
        .i_step  (step),
        .i_rdata (rdata),
        .o_bus   (cpu_bus),
        .o_halt  (o_halt)
    );

    program_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_program_ram (
        .clk         (clk),
        .i_bus       (cpu_bus),
        .i_wr_strobe (wr_strobe),
        .i_load      (load_bus),
        .o_rdata     (rdata)
    );

    led_port u_led_port (
        .clk         (clk),
        .i_reset     (led_reset),
        .i_bus       (cpu_bus),
        .i_wr_strobe (wr_strobe),
        .o_led       (o_led)
    );

endmodule

/* program_ram.sv */
// Shared program and data RAM
`timescale 1ns/1ps

module program_ram #(
    parameter int RAM_ADDR_W = 10  // Upper bus address bits mirror
) (
    input  logic                clk,
    input  calc_pkg::cpu_bus_t  i_bus,
    input  logic                i_wr_strobe,  // One per store cycle
    input  calc_pkg::load_bus_t i_load,       // Host port, stopped only
    output logic [7:0]          o_rdata
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [7:0]            mem [DEPTH];
    logic [RAM_ADDR_W-1:0] cpu_idx;   // Mirrored processor address
    logic [RAM_ADDR_W-1:0] load_idx;
    logic                  cpu_wr;

    assign cpu_idx  = i_bus.addr[RAM_ADDR_W-1:0];
    assign load_idx = i_load.addr[RAM_ADDR_W-1:0];

    // LED stores must not land in the mirrored RAM byte
    assign cpu_wr = i_wr_strobe && (i_bus.addr != calc_pkg::LED_ADDR);

    // ------------------------------------------------------------------------
    // Write ports
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cpu_wr) begin
            mem[cpu_idx] <= i_bus.wdata;
        end else if (i_load.en) begin
            mem[load_idx] <= i_load.data;  // Program load
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // One clock latency, ready well before the last phase
    always_ff @(posedge clk) begin
        o_rdata <= mem[cpu_idx];
    end

    // Host loads only while the processor is stopped
    a_no_load_while_running : assert property (@(posedge clk)
        !(i_load.en && i_wr_strobe));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_calc -f list.f -o sim_calc \
    && ./obj_dir/sim_calc \
    || { echo "Simulation failed"; exit 1; }

echo "Simulation finished"

/* tb_calc.sv */
// Calculator subsystem testbench
`timescale 1ns/1ps

module tb_calc;

    localparam int PHASES     = 4;    // Fast clocks per processor cycle
    localparam int RAM_ADDR_W = 10;
    localparam int CLK_NS     = 8;
    localparam int VEC_DEPTH  = 512;  // Bytes of the vectors file

    logic                clk;
    logic                i_reset;
    logic                i_run;
    calc_pkg::load_bus_t i_load;
    logic [3:0]          o_led;
    logic                o_halt;

    logic [7:0] vec_mem [VEC_DEPTH];  // Whole vectors file
    int         rd_pos;               // Next byte to consume
    longint     budget_ns;            // Watchdog limit held at zero until sized
    logic [3:0] led_seen [$];         // LED history of one run

    marsohod_calc_top #(
        .PHASES     (PHASES),
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_marsohod_calc_top (
        .clk     (clk),
        .i_reset (i_reset),
        .i_run   (i_run),
        .i_load  (i_load),
        .o_led   (o_led),
        .o_halt  (o_halt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] next_byte();
        next_byte = vec_mem[rd_pos];
        rd_pos    = rd_pos + 1;
    endfunction

    // Worst case cycles per byte scaled by the loop factor plus load time
    function automatic longint test_budget_ns(input int len, input int factor);
        return longint'(len) * 4 * PHASES * CLK_NS * factor
             + longint'(len + 16) * CLK_NS * 2;
    endfunction

    // Program bytes go to address 0 upward at one per clock
    task automatic load_program(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            i_load.en   <= 1'b1;
            i_load.addr <= 16'(i);
            i_load.data <= next_byte();
        end
        @(posedge clk);
        i_load.en <= 1'b0;
    endtask

    // Every LED change until the core halts
    task automatic capture_leds();
        logic [3:0] last;
        last = 4'h0;  // Cleared while stopped
        led_seen.delete();
        while (o_halt !== 1'b1) begin
            @(negedge clk);
            if (o_led !== last) begin
                led_seen.push_back(o_led);
                last = o_led;
            end
        end
    endtask

    task automatic compare_leds(input int nexp);
        check_value("LED change count", 32'(led_seen.size()), 32'(nexp));
        for (int i = 0; i < nexp; i++) begin
            check_value($sformatf("LED value %0d", i), 32'(led_seen[i]), 32'(next_byte()));
        end
    endtask

    // Stop acts as reset so LEDs and halt clear one clock later
    task automatic stop_core();
        @(posedge clk);
        i_run <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("o_led after stop", 32'(o_led), 32'd0);
        check_value("o_halt after stop", 32'(o_halt), 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------
    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("Timeout after %0d ns, a test program never halted", budget_ns);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int                num_tests;
        int                len;
        int                nexp;
        int                factor;
        longint            total_ns;
        calc_pkg::opcode_e first_op;
        i_reset   = 1'b1;
        i_run     = 1'b0;
        i_load    = '0;
        budget_ns = 0;
        rd_pos    = 0;
        $readmemh("calc_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[0]) || vec_mem[0] == 8'h00) begin
            $display("Could not read the test count from calc_vectors.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "no vectors");
        end
        num_tests = int'(next_byte());
        total_ns  = 10 * CLK_NS;  // Reset and first check
        for (int t = 0; t < num_tests; t++) begin  // Sizing pass
            len      = int'(next_byte());
            nexp     = int'(next_byte());
            factor   = int'(next_byte());
            total_ns = total_ns + test_budget_ns(len, factor);
            rd_pos   = rd_pos + len + nexp;
        end
        budget_ns = total_ns;
        rd_pos    = 1;

        repeat (3) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_led after reset", 32'(o_led), 32'd0);
        check_value("o_halt after reset", 32'(o_halt), 32'd0);

        for (int t = 0; t < num_tests; t++) begin
            len      = int'(next_byte());
            nexp     = int'(next_byte());
            factor   = int'(next_byte());
            first_op = calc_pkg::opcode_e'(vec_mem[rd_pos]);
            $display("Test %0d: %0d bytes, loop factor %0d, starts with %s",
                     t, len, factor, first_op.name());
            load_program(len);
            @(posedge clk);
            i_run <= 1'b1;   // Fetch from reset address
            capture_leds();
            compare_leds(nexp);
            stop_core();     // Next program restarts clean
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
